// ==== common/cbus_pkg.sv ====
`default_nettype none

package cbus_pkg;

	// ########################################################################
	// Bus widths.
	// ########################################################################

	localparam int ADDR_W = 64;
	localparam int DATA_W = 64;
	localparam int LEN_W = 8; // Beat count minus one.
	localparam int STRB_W = DATA_W / 8;

	typedef enum logic [1:0] {
		BURST_FIXED = 2'b00,
		BURST_INCR = 2'b01,
		BURST_WRAP = 2'b10
	} burst_t;

	typedef enum logic [2:0] {
		MSIZE1 = 3'b000,
		MSIZE2 = 3'b001,
		MSIZE4 = 3'b010,
		MSIZE8 = 3'b011,
		MSIZE16 = 3'b100,
		MSIZE32 = 3'b101,
		MSIZE64 = 3'b110,
		MSIZE128 = 3'b111
	} size_t;

	typedef enum logic [1:0] {
		REGION_RAM,
		REGION_TIMER,
		REGION_STUB,
		REGION_NONE
	} region_t;

	// ########################################################################
	// Address map.
	// ########################################################################

	localparam logic [3:0] RAM_NIBBLE = 4'h8; // 0x8000_0000 .. 0x8FFF_FFFF.
	localparam logic [ADDR_W-1:0] TIMER_ADDR = 64'h3800_bff8;
	localparam logic [ADDR_W-1:0] STUB_ADDR = 64'h4060_0008;

	// Word index of a byte address, wrapped to the array depth.
	function automatic logic [31:0] word_index(input logic [ADDR_W-1:0] addr,
		input int unsigned depth);
		return 32'((addr >> 3) % ADDR_W'(depth));
	endfunction

endpackage

`default_nettype wire

// ==== common/cbus_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// Decoded request descriptor, decode stage to beat stage.
interface cbus_if #(
	parameter int SRAM_DEPTH = 1024
) ();

	localparam int IDX_W = $clog2(SRAM_DEPTH);

	logic desc_valid;
	logic is_write;
	cbus_pkg::region_t region;
	logic [IDX_W-1:0] base_index; // Word index of the first beat.
	logic [cbus_pkg::LEN_W-1:0] len;
	logic is_fixed;
	logic error; // Request is not performed.
	logic desc_done; // Last beat is on the bus this cycle.

	modport decoder (
		output desc_valid,
		output is_write,
		output region,
		output base_index,
		output len,
		output is_fixed,
		output error,
		input desc_done
	);

	modport sequencer (
		input desc_valid,
		input is_write,
		input region,
		input base_index,
		input len,
		input is_fixed,
		input error,
		output desc_done
	);

endinterface

`default_nettype wire

// ==== hw/mmio_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

// Free-running tick count, one tick per TIMER_DIV clocks.
module mmio_timer #(
	parameter int TIMER_DIV = 10
) (
	input logic clk,
	input logic reset,

	output logic [cbus_pkg::DATA_W-1:0] count
);

	localparam int PRE_W = (TIMER_DIV > 1) ? $clog2(TIMER_DIV) : 1;

	logic [PRE_W-1:0] prescale;
	logic wrap;

	assign wrap = (prescale == PRE_W'(TIMER_DIV - 1));

	// ########################################################################
	// Prescaler and count.
	// ########################################################################

	always_ff @(posedge clk) begin
		if (reset) begin
			prescale <= '0;
		end else if (wrap) begin
			prescale <= '0;
		end else begin
			prescale <= prescale + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			count <= '0;
		else if (wrap)
			count <= count + 1'b1;
	end

endmodule

`default_nettype wire

// ==== sram/sram_array.sv ====
`timescale 1ns/1ns
`default_nettype none

module sram_array #(
	parameter int SRAM_DEPTH = 1024
) (
	input logic clk,

	input logic [$clog2(SRAM_DEPTH)-1:0] index,
	input logic [cbus_pkg::DATA_W-1:0] wdata,
	input logic [cbus_pkg::DATA_W-1:0] mask, // One bit per data bit.
	input logic wen,

	output logic [cbus_pkg::DATA_W-1:0] rdata
);

	logic [cbus_pkg::DATA_W-1:0] mem [SRAM_DEPTH];
	logic [cbus_pkg::DATA_W-1:0] merged;

	// ########################################################################
	// Read port.
	// ########################################################################

	assign rdata = mem[index];

	// ########################################################################
	// Byte-masked write port.
	// ########################################################################

	// Keep unselected bytes of the old word.
	assign merged = (rdata & ~mask) | (wdata & mask);

	always_ff @(posedge clk) begin
		if (wen)
			mem[index] <= merged;
	end

endmodule

`default_nettype wire

// ==== hw/cbus_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module cbus_decoder #(
	parameter int SRAM_DEPTH = 1024
) (
	input logic clk,
	input logic reset,

	input logic req_valid,
	input logic req_is_write,
	input logic [cbus_pkg::ADDR_W-1:0] req_addr,
	input cbus_pkg::size_t req_size,
	input cbus_pkg::burst_t req_burst,
	input logic [cbus_pkg::LEN_W-1:0] req_len,

	cbus_if.decoder bus
);

	localparam int IDX_W = $clog2(SRAM_DEPTH);

	cbus_pkg::region_t region;
	logic legal;
	logic holdoff; // Blocks the cycle after desc_done.
	logic capture;

	// ########################################################################
	// Region and legality.
	// ########################################################################

	always_comb begin
		if (req_addr == cbus_pkg::TIMER_ADDR)
			region = cbus_pkg::REGION_TIMER;
		else if (req_addr == cbus_pkg::STUB_ADDR)
			region = cbus_pkg::REGION_STUB;
		else if (req_addr[cbus_pkg::ADDR_W-1:32] == '0
			&& req_addr[31:28] == cbus_pkg::RAM_NIBBLE)
			region = cbus_pkg::REGION_RAM;
		else
			region = cbus_pkg::REGION_NONE;
	end

	// FIXED at any size, INCR only with full words.
	assign legal = (req_burst == cbus_pkg::BURST_FIXED)
		|| (req_burst == cbus_pkg::BURST_INCR && req_size == cbus_pkg::MSIZE8);

	assign capture = req_valid && !bus.desc_valid && !holdoff;

	// ########################################################################
	// Descriptor register.
	// ########################################################################

	always_ff @(posedge clk) begin
		if (reset) begin
			bus.desc_valid <= 1'b0;
			holdoff <= 1'b0;
		end else begin
			holdoff <= bus.desc_valid && bus.desc_done;
			if (bus.desc_valid && bus.desc_done)
				bus.desc_valid <= 1'b0;
			else if (capture)
				bus.desc_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			bus.is_write <= req_is_write;
			bus.region <= region;
			bus.base_index <= IDX_W'(cbus_pkg::word_index(req_addr, SRAM_DEPTH));
			bus.len <= req_len;
			bus.is_fixed <= (req_burst == cbus_pkg::BURST_FIXED);
			bus.error <= !legal;
		end
	end

endmodule

`default_nettype wire

// ==== hw/burst_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module burst_sequencer #(
	parameter int ACCESS_LATENCY = 3,
	parameter int SRAM_DEPTH = 1024
) (
	input logic clk,
	input logic reset,

	cbus_if.sequencer bus,

	input logic [cbus_pkg::STRB_W-1:0] req_strobe,
	input logic [cbus_pkg::DATA_W-1:0] req_data,

	output logic [$clog2(SRAM_DEPTH)-1:0] sram_index,
	output logic [cbus_pkg::DATA_W-1:0] sram_wdata,
	output logic [cbus_pkg::DATA_W-1:0] sram_mask,
	output logic sram_wen,
	input logic [cbus_pkg::DATA_W-1:0] sram_rdata,

	input logic [cbus_pkg::DATA_W-1:0] timer_count,

	output logic resp_ready,
	output logic resp_last,
	output logic resp_error,
	output logic [cbus_pkg::DATA_W-1:0] resp_data
);

	localparam int IDX_W = $clog2(SRAM_DEPTH);
	localparam int LAT_W = (ACCESS_LATENCY > 0) ? $clog2(ACCESS_LATENCY + 1) : 1;
	localparam int SUM_W = IDX_W + cbus_pkg::LEN_W + 1;

	typedef enum logic {
		S_WAIT,
		S_BEAT
	} state_t;

	state_t state;
	logic [LAT_W-1:0] lat_cnt;
	logic [cbus_pkg::LEN_W-1:0] beat_num;
	logic [cbus_pkg::LEN_W-1:0] final_beat;
	logic lat_done;
	logic beat;
	logic last;
	logic [SUM_W-1:0] beat_sum;

	// ########################################################################
	// Beat control.
	// ########################################################################

	assign lat_done = (lat_cnt == LAT_W'(ACCESS_LATENCY));
	assign beat = (state == S_BEAT) || (bus.desc_valid && lat_done);
	assign final_beat = (bus.is_fixed || bus.error) ? '0 : bus.len; // Single beat.
	assign last = (beat_num == final_beat);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_WAIT;
			lat_cnt <= '0;
			beat_num <= '0;
		end else if (beat) begin
			lat_cnt <= '0;
			if (last) begin
				state <= S_WAIT;
				beat_num <= '0;
			end else begin
				state <= S_BEAT;
				beat_num <= beat_num + 1'b1;
			end
		end else if (bus.desc_valid) begin
			lat_cnt <= lat_cnt + 1'b1; // Slow memory.
		end
	end

	assign bus.desc_done = beat && last;

	// ########################################################################
	// Storage side.
	// ########################################################################

	assign beat_sum = SUM_W'(bus.base_index) + SUM_W'(beat_num);
	assign sram_index = IDX_W'(beat_sum % SUM_W'(SRAM_DEPTH));
	assign sram_wdata = req_data;
	assign sram_wen = beat && bus.is_write && !bus.error
		&& (bus.region == cbus_pkg::REGION_RAM);

	for (genvar i = 0; i < cbus_pkg::STRB_W; i++) begin : g_mask
		assign sram_mask[i*8 +: 8] = {8{req_strobe[i]}};
	end

	// ########################################################################
	// Response.
	// ########################################################################

	assign resp_ready = beat;
	assign resp_last = beat && last;
	assign resp_error = beat && bus.error;

	always_comb begin
		case (bus.region)
			cbus_pkg::REGION_TIMER: resp_data = timer_count;
			cbus_pkg::REGION_STUB: resp_data = '0;
			default: resp_data = sram_rdata; // Unmapped reads alias the array.
		endcase
		if (bus.error)
			resp_data = '0;
	end

endmodule

`default_nettype wire

// ==== hw/cbus_sram_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cbus_sram_top #(
	parameter int SRAM_DEPTH = 1024,
	parameter int ACCESS_LATENCY = 3,
	parameter int TIMER_DIV = 10
) (
	input logic clk,
	input logic reset,

	// CBus request, held by the master until the last beat.
	input logic req_valid,
	input logic req_is_write,
	input logic [cbus_pkg::ADDR_W-1:0] req_addr,
	input cbus_pkg::size_t req_size,
	input cbus_pkg::burst_t req_burst,
	input logic [cbus_pkg::LEN_W-1:0] req_len,
	input logic [cbus_pkg::STRB_W-1:0] req_strobe,
	input logic [cbus_pkg::DATA_W-1:0] req_data,

	// CBus response.
	output logic resp_ready,
	output logic resp_last,
	output logic resp_error,
	output logic [cbus_pkg::DATA_W-1:0] resp_data
);

	localparam int IDX_W = $clog2(SRAM_DEPTH);

	logic [IDX_W-1:0] sram_index;
	logic [cbus_pkg::DATA_W-1:0] sram_wdata;
	logic [cbus_pkg::DATA_W-1:0] sram_mask;
	logic sram_wen;
	logic [cbus_pkg::DATA_W-1:0] sram_rdata;
	logic [cbus_pkg::DATA_W-1:0] timer_count;

	cbus_if #(.SRAM_DEPTH(SRAM_DEPTH)) desc_bus ();

	// ########################################################################
	// Stages.
	// ########################################################################

	cbus_decoder #(.SRAM_DEPTH(SRAM_DEPTH)) decoder (
		.clk, .reset,
		.req_valid, .req_is_write, .req_addr, .req_size, .req_burst, .req_len,
		.bus(desc_bus.decoder)
	);

	burst_sequencer #(
		.ACCESS_LATENCY(ACCESS_LATENCY),
		.SRAM_DEPTH(SRAM_DEPTH)
	) sequencer (
		.clk, .reset,
		.bus(desc_bus.sequencer),
		.req_strobe, .req_data,
		.sram_index, .sram_wdata, .sram_mask, .sram_wen, .sram_rdata,
		.timer_count,
		.resp_ready, .resp_last, .resp_error, .resp_data
	);

	mmio_timer #(.TIMER_DIV(TIMER_DIV)) timer (
		.clk, .reset,
		.count(timer_count)
	);

	sram_array #(.SRAM_DEPTH(SRAM_DEPTH)) sram (
		.clk,
		.index(sram_index),
		.wdata(sram_wdata),
		.mask(sram_mask),
		.wen(sram_wen),
		.rdata(sram_rdata)
	);

endmodule

`default_nettype wire

// ==== test/cbus_sram_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

// CBus handshake rules, seen at the top-level ports.
module cbus_sram_checker (
	input logic clk,
	input logic reset,
	input logic req_valid,
	input logic req_is_write,
	input logic [cbus_pkg::ADDR_W-1:0] req_addr,
	input cbus_pkg::size_t req_size,
	input cbus_pkg::burst_t req_burst,
	input logic [cbus_pkg::LEN_W-1:0] req_len,
	input logic [cbus_pkg::STRB_W-1:0] req_strobe,
	input logic resp_ready,
	input logic resp_last,
	input logic resp_error
);

	logic [85:0] req_fields; // Everything but req_data.

	assign req_fields = {req_is_write, req_addr, req_size, req_burst, req_len, req_strobe};

	last_needs_ready: assert property (@(posedge clk) disable iff (reset)
		resp_last |-> resp_ready)
		else $error("resp_last high without resp_ready");

	ready_needs_valid: assert property (@(posedge clk) disable iff (reset)
		!req_valid |-> !resp_ready)
		else $error("resp_ready high with no request");

	// Fields may change only after the edge that takes the last beat.
	request_held: assert property (@(posedge clk) disable iff (reset)
		(req_valid && !(resp_ready && resp_last)) |=> $stable(req_fields))
		else $error("request fields changed before the last beat");

	error_is_last: assert property (@(posedge clk) disable iff (reset)
		resp_error |-> resp_last)
		else $error("resp_error on a beat that is not the last");

endmodule

bind cbus_sram_top cbus_sram_checker handshake_check (
	.clk(clk), .reset(reset),
	.req_valid(req_valid), .req_is_write(req_is_write), .req_addr(req_addr),
	.req_size(req_size), .req_burst(req_burst), .req_len(req_len),
	.req_strobe(req_strobe),
	.resp_ready(resp_ready), .resp_last(resp_last), .resp_error(resp_error)
);

`default_nettype wire

// ==== test/cbus_sram_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cbus_sram_tb;

	localparam int SRAM_DEPTH = 1024;
	localparam int ACCESS_LATENCY = 3;
	localparam int TIMER_DIV = 10;
	localparam int TIMER_GAP = 57;
	localparam int WORST_BEATS = 50; // Error bursts counted at their full length.
	localparam int WATCHDOG_CYCLES = WORST_BEATS * 20 + TIMER_GAP + 100;

	logic clk;
	logic reset;
	logic req_valid;
	logic req_is_write;
	logic [63:0] req_addr;
	cbus_pkg::size_t req_size;
	cbus_pkg::burst_t req_burst;
	logic [7:0] req_len;
	logic [7:0] req_strobe;
	logic [63:0] req_data;
	logic resp_ready;
	logic resp_last;
	logic resp_error;
	logic [63:0] resp_data;

	logic [63:0] ref_mem [int]; // Reference SRAM, keyed by word index.
	logic [63:0] wr_data [$];
	logic [63:0] rd_data [$];
	logic rd_last [$];
	logic rd_error [$];
	int first_latency;
	int first_cycle;
	int cycle_count = 0;
	int error_count = 0;
	int test_count = 0;
	logic [31:0] lfsr_state = 32'h29f73c32;

	cbus_sram_top #(
		.SRAM_DEPTH(SRAM_DEPTH),
		.ACCESS_LATENCY(ACCESS_LATENCY),
		.TIMER_DIV(TIMER_DIV)
	) UUT (
		.clk, .reset,
		.req_valid, .req_is_write, .req_addr, .req_size, .req_burst, .req_len,
		.req_strobe, .req_data,
		.resp_ready, .resp_last, .resp_error, .resp_data
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the bridge stopped answering, run ended by the watchdog");
		$display("FAIL: see errors above");
		$finish;
	end

	// ########################################################################
	// Helpers.
	// ########################################################################

	// Fibonacci LFSR, taps 32 22 2 1.
	function automatic logic [63:0] random_bits(input int count);
		logic [63:0] bits;
		logic fb;
		int i;
		bits = '0;
		for (i = 0; i < count; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			bits = {bits[62:0], fb};
		end
		return bits;
	endfunction

	function automatic int ram_index(input logic [63:0] addr);
		return int'((addr >> 3) % SRAM_DEPTH);
	endfunction

	task automatic report_mismatch(input string name, input string what,
		input logic [63:0] expected, input logic [63:0] actual);
		$display("FAIL %s: %s expected %0h, actual %0h", name, what, expected, actual);
		error_count++;
	endtask

	task automatic finish_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, error_count - errors_before);
	endtask

	task automatic idle_cycles(input int count);
		repeat (count) @(posedge clk);
		#1;
	endtask

	task automatic fill_write_data(input int beats);
		wr_data.delete();
		repeat (beats) wr_data.push_back(random_bits(64));
	endtask

	// One request, held until its last beat. Starts and ends 1 ns after an edge.
	task automatic do_request(input logic is_write, input logic [63:0] addr,
		input cbus_pkg::size_t size, input cbus_pkg::burst_t burst,
		input logic [7:0] len, input logic [7:0] strobe);
		int edges;
		logic got_last;
		edges = 0;
		got_last = 1'b0;
		first_latency = -1;
		rd_data.delete();
		rd_last.delete();
		rd_error.delete();
		req_valid = 1'b1;
		req_is_write = is_write;
		req_addr = addr;
		req_size = size;
		req_burst = burst;
		req_len = len;
		req_strobe = strobe;
		req_data = (wr_data.size() > 0) ? wr_data[0] : '0;
		while (!got_last) begin
			@(negedge clk);
			if (resp_ready) begin
				if (rd_data.size() == 0) begin
					first_latency = edges;
					first_cycle = cycle_count;
				end
				rd_data.push_back(resp_data);
				rd_last.push_back(resp_last);
				rd_error.push_back(resp_error);
				got_last = resp_last;
			end
			@(posedge clk);
			#1;
			edges++;
			if (!got_last && rd_data.size() < wr_data.size())
				req_data = wr_data[rd_data.size()]; // Next beat's word.
		end
		req_valid = 1'b0;
		req_data = '0;
		idle_cycles(1);
	endtask

	task automatic model_write(input logic [63:0] addr, input logic [7:0] len,
		input logic [7:0] strobe);
		int i;
		int b;
		int idx;
		logic [63:0] word;
		for (i = 0; i <= len; i++) begin
			idx = (ram_index(addr) + i) % SRAM_DEPTH;
			word = ref_mem.exists(idx) ? ref_mem[idx] : 'x;
			for (b = 0; b < 8; b++) begin
				if (strobe[b])
					word[8*b +: 8] = wr_data[i][8*b +: 8];
			end
			ref_mem[idx] = word;
		end
	endtask

	task automatic check_response(input string name, input int beats, input logic error);
		int i;
		if (rd_data.size() != beats)
			report_mismatch(name, "beat count", beats, rd_data.size());
		if (first_latency != 1 + ACCESS_LATENCY)
			report_mismatch(name, "first beat latency", 1 + ACCESS_LATENCY, first_latency);
		for (i = 0; i < rd_data.size(); i++) begin
			if (rd_last[i] !== (i == beats - 1))
				report_mismatch(name, "resp_last", i == beats - 1, rd_last[i]);
			if (rd_error[i] !== error)
				report_mismatch(name, "resp_error", error, rd_error[i]);
			if (error && rd_data[i] !== '0)
				report_mismatch(name, "error beat data", '0, rd_data[i]);
		end
	endtask

	task automatic check_read_back(input string name, input logic [63:0] addr);
		int i;
		int idx;
		for (i = 0; i < rd_data.size(); i++) begin
			idx = (ram_index(addr) + i) % SRAM_DEPTH;
			if (rd_data[i] !== ref_mem[idx])
				report_mismatch(name, "read data", ref_mem[idx], rd_data[i]);
		end
	endtask

	// ########################################################################
	// Directed tests.
	// ########################################################################

	task automatic test_single_access;
		string name;
		int errors_before;
		logic [63:0] addr;
		name = "single_access";
		errors_before = error_count;
		addr = 64'h8000_0100;
		fill_write_data(1);
		do_request(1'b1, addr, cbus_pkg::MSIZE8, cbus_pkg::BURST_FIXED, 8'd0, 8'hff);
		check_response(name, 1, 1'b0);
		model_write(addr, 8'd0, 8'hff);
		wr_data.delete();
		do_request(1'b0, addr, cbus_pkg::MSIZE8, cbus_pkg::BURST_FIXED, 8'd0, 8'h00);
		check_response(name, 1, 1'b0);
		check_read_back(name, addr);
		finish_test(name, errors_before);
	endtask

	task automatic test_incr_burst;
		string name;
		int errors_before;
		logic [63:0] addr;
		logic [7:0] strobe;
		name = "incr_burst";
		errors_before = error_count;
		addr = 64'h8000_1fe0; // Index 1020, so the burst wraps to 0.
		fill_write_data(8);
		do_request(1'b1, addr, cbus_pkg::MSIZE8, cbus_pkg::BURST_INCR, 8'd7, 8'hff);
		check_response(name, 8, 1'b0);
		model_write(addr, 8'd7, 8'hff);
		strobe = random_bits(8);
		fill_write_data(8);
		do_request(1'b1, addr, cbus_pkg::MSIZE8, cbus_pkg::BURST_INCR, 8'd7, strobe);
		check_response(name, 8, 1'b0);
		model_write(addr, 8'd7, strobe);
		wr_data.delete();
		do_request(1'b0, addr, cbus_pkg::MSIZE8, cbus_pkg::BURST_INCR, 8'd7, 8'h00);
		check_response(name, 8, 1'b0);
		check_read_back(name, addr);
		finish_test(name, errors_before);
	endtask

	task automatic test_region_decode;
		string name;
		int errors_before;
		name = "region_decode";
		errors_before = error_count;
		fill_write_data(1); // Index 1, the word that STUB_ADDR would alias.
		do_request(1'b1, 64'h8000_0008, cbus_pkg::MSIZE8, cbus_pkg::BURST_FIXED, 8'd0, 8'hff);
		check_response(name, 1, 1'b0);
		model_write(64'h8000_0008, 8'd0, 8'hff);
		wr_data.delete();
		do_request(1'b0, cbus_pkg::STUB_ADDR, cbus_pkg::MSIZE8, cbus_pkg::BURST_FIXED,
			8'd0, 8'h00);
		check_response(name, 1, 1'b0);
		if (rd_data.size() > 0 && rd_data[0] !== '0)
			report_mismatch(name, "stub data", '0, rd_data[0]);
		fill_write_data(1);
		do_request(1'b1, 64'h8000_0200, cbus_pkg::MSIZE8, cbus_pkg::BURST_FIXED, 8'd0, 8'hff);
		check_response(name, 1, 1'b0);
		model_write(64'h8000_0200, 8'd0, 8'hff);
		fill_write_data(1); // Same word index, top nibble 1, so dropped.
		do_request(1'b1, 64'h1000_0200, cbus_pkg::MSIZE8, cbus_pkg::BURST_FIXED, 8'd0, 8'hff);
		check_response(name, 1, 1'b0);
		wr_data.delete();
		do_request(1'b0, 64'h8000_0200, cbus_pkg::MSIZE8, cbus_pkg::BURST_FIXED, 8'd0, 8'h00);
		check_response(name, 1, 1'b0);
		check_read_back(name, 64'h8000_0200);
		do_request(1'b0, 64'h1000_0200, cbus_pkg::MSIZE8, cbus_pkg::BURST_FIXED, 8'd0, 8'h00);
		check_response(name, 1, 1'b0);
		check_read_back(name, 64'h1000_0200);
		finish_test(name, errors_before);
	endtask

	task automatic test_timer;
		string name;
		int errors_before;
		logic [63:0] t0;
		int c0;
		int ticks;
		int exp_ticks;
		name = "timer";
		errors_before = error_count;
		wr_data.delete();
		do_request(1'b0, cbus_pkg::TIMER_ADDR, cbus_pkg::MSIZE8, cbus_pkg::BURST_FIXED,
			8'd0, 8'h00);
		check_response(name, 1, 1'b0);
		t0 = (rd_data.size() > 0) ? rd_data[0] : '0;
		c0 = first_cycle;
		idle_cycles(TIMER_GAP);
		do_request(1'b0, cbus_pkg::TIMER_ADDR, cbus_pkg::MSIZE8, cbus_pkg::BURST_FIXED,
			8'd0, 8'h00);
		check_response(name, 1, 1'b0);
		ticks = int'(((rd_data.size() > 0) ? rd_data[0] : '0) - t0);
		exp_ticks = (first_cycle - c0) / TIMER_DIV;
		if (ticks < exp_ticks - 1 || ticks > exp_ticks + 1)
			report_mismatch(name, "tick delta", exp_ticks, ticks);
		finish_test(name, errors_before);
	endtask

	task automatic test_error_response;
		string name;
		int errors_before;
		logic [63:0] addr;
		name = "error_response";
		errors_before = error_count;
		addr = 64'h8000_0300;
		fill_write_data(4);
		do_request(1'b1, addr, cbus_pkg::MSIZE8, cbus_pkg::BURST_INCR, 8'd3, 8'hff);
		check_response(name, 4, 1'b0);
		model_write(addr, 8'd3, 8'hff);
		fill_write_data(4);
		do_request(1'b1, addr, cbus_pkg::MSIZE8, cbus_pkg::BURST_WRAP, 8'd3, 8'hff);
		check_response(name, 1, 1'b1);
		fill_write_data(4);
		do_request(1'b1, addr, cbus_pkg::MSIZE4, cbus_pkg::BURST_INCR, 8'd3, 8'hff);
		check_response(name, 1, 1'b1);
		wr_data.delete();
		do_request(1'b0, addr, cbus_pkg::MSIZE8, cbus_pkg::BURST_INCR, 8'd3, 8'h00);
		check_response(name, 4, 1'b0);
		check_read_back(name, addr);
		finish_test(name, errors_before);
	endtask

	// ########################################################################
	// Sequence.
	// ########################################################################

	initial begin
		reset = 1'b1;
		req_valid = 1'b0;
		req_is_write = 1'b0;
		req_addr = '0;
		req_size = cbus_pkg::MSIZE8;
		req_burst = cbus_pkg::BURST_FIXED;
		req_len = '0;
		req_strobe = '0;
		req_data = '0;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		idle_cycles(1);
		test_single_access();
		test_incr_burst();
		test_region_decode();
		test_timer();
		test_error_response();
		$display("Tests run: %0d, errors: %0d", test_count, error_count);
		if (error_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// ==== cbus_sram_top.f ====
common/cbus_pkg.sv
common/cbus_if.sv
hw/mmio_timer.sv
sram/sram_array.sv
hw/cbus_decoder.sv
hw/burst_sequencer.sv
hw/cbus_sram_top.sv
test/cbus_sram_checker.sv
test/cbus_sram_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CBus bridge testbench, then look for the pass line in the log.

verilator --binary --timing --assert -Wno-fatal \
	--top-module cbus_sram_tb -f cbus_sram_top.f \
	-Mdir obj_dir -o cbus_sram_sim \
	&& ./obj_dir/cbus_sram_sim > sim.log 2>&1 \
	|| { echo "build or simulation run failed, see sim.log"; exit 1; }

grep -qx "PASS: all tests" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
